// ==== verilog.f ====
logic/elink_pkg.sv
logic/sync_fifo.sv
logic/data_gen_elink_sm.sv
logic/enc_8b10b.sv
logic/fifo_to_elink.sv
logic/dec_8b10b.sv
logic/elink_to_fifo.sv
logic/elink_loopback_top.sv
testbench/tb_elink_loopback.sv

// ==== Bender.yml ====
package:
  name: elink_loopback

sources:
  - files:
      - logic/elink_pkg.sv
      - logic/sync_fifo.sv
      - logic/data_gen_elink_sm.sv
      - logic/enc_8b10b.sv
      - logic/fifo_to_elink.sv
      - logic/dec_8b10b.sv
      - logic/elink_to_fifo.sv
      - logic/elink_loopback_top.sv
  - target: simulation
    files:
      - testbench/tb_elink_loopback.sv

// ==== testbench/tb_elink_loopback.sv ====
module tb_elink_loopback;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int MAX_PKTS = 512;

  logic                   clk;
  logic                   rst_n;
  logic                   loop_en;
  logic [7:0]             packet_len;
  logic                   rx_rd_en;
  elink_pkg::elink_word_t rx_word;
  logic                   rx_empty;
  logic                   rx_aligned;
  logic                   rx_code_err;
  logic                   rx_overflow;
  logic                   done;

  integer seed;
  string  test_name;
  int     pkt_lens [MAX_PKTS];
  int     n_lens;
  int     payload_total;
  int     rd_pkt;
  int     rd_pos;
  bit     seen [256];

  elink_loopback_top UUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .loop_en     (loop_en),
    .packet_len  (packet_len),
    .rx_rd_en    (rx_rd_en),
    .rx_word     (rx_word),
    .rx_empty    (rx_empty),
    .rx_aligned  (rx_aligned),
    .rx_code_err (rx_code_err),
    .rx_overflow (rx_overflow),
    .done        (done)
  );

  always #20 clk = ~clk;

  // a packet is a SOP, then pkt_lens[pkt] counting bytes, then an EOP.
  function automatic elink_pkg::elink_word_t exp_word(input int pkt, input int pos);
    elink_pkg::elink_word_t w;
    int base;
    base = 0;
    for (int i = 0; i < pkt; i++)
    begin
      base = base + pkt_lens[i];
    end
    if (pos == 0)
    begin
      w.delim = elink_pkg::DELIM_SOP;
      w.data  = elink_pkg::K28_1;
    end
    else if (pos <= pkt_lens[pkt])
    begin
      w.delim = elink_pkg::DELIM_DATA;
      w.data  = 8'((base + pos - 1) % 256);
    end
    else
    begin
      w.delim = elink_pkg::DELIM_EOP;
      w.data  = elink_pkg::K28_6;
    end
    return w;
  endfunction

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("ERROR %s: expected 0x%0h, actual 0x%0h", what, expected, actual);
      $display("Result: FAILED");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  task automatic timed_out(input string what);
    $display("Timeout: %s did not happen in time.", what);
    $display("Result: FAILED");
    $fatal(1, "wait limit exceeded");
  endtask

  task automatic check_reset_state();
    check_value(test_name, 32'd1, rx_empty);
    check_value(test_name, 32'd0, done);
    check_value(test_name, 32'd0, rx_aligned);
    check_value(test_name, 32'd0, rx_code_err);
    check_value(test_name, 32'd0, rx_overflow);
  endtask

  // records the length of the next packet before the generator writes its SOP.
  task automatic start_next(input int len);
    pkt_lens[n_lens] = len;
    n_lens++;
    payload_total += len;
    packet_len <= 8'(len);
  endtask

  task automatic wait_done(input int limit);
    int n;
    n = 0;
    @(posedge clk);
    while (!done && n < limit)
    begin
      @(posedge clk);
      n++;
    end
    if (!done)
    begin
      timed_out("a done pulse from the generator");
    end
  endtask

  task automatic wait_aligned(input int limit);
    int n;
    n = 0;
    while (!rx_aligned && n < limit)
    begin
      @(posedge clk);
      n++;
      check_value(test_name, 32'd1, rx_empty);
    end
    if (!rx_aligned)
    begin
      timed_out("receiver alignment on the comma stream");
    end
  endtask

  task automatic wait_drained(input int limit);
    int n;
    n = 0;
    while (rd_pkt < n_lens && n < limit)
    begin
      @(posedge clk);
      n++;
    end
    if (rd_pkt < n_lens)
    begin
      timed_out("reading back every packet");
    end
  endtask

  // reads only follow an idle cycle, so the FIFO cannot run empty under a read.
  always @(posedge clk)
  begin
    int r;
    r = $random(seed);
    if (!rst_n)
    begin
      rx_rd_en <= 1'b0;
    end
    else
    begin
      rx_rd_en <= !rx_rd_en && !rx_empty && r[0];
    end
  end

  always @(posedge clk)
  begin : compare_words
    elink_pkg::elink_word_t want;
    if (rst_n && rx_rd_en && !rx_empty)
    begin
      if (rd_pkt >= n_lens)
      begin
        $display("Word 0x%0h arrived after the last packet had ended.", rx_word);
        $display("Result: FAILED");
        $fatal(1, "unexpected word");
      end
      else
      begin
        want = exp_word(rd_pkt, rd_pos);
        check_value(test_name, want, rx_word);
        if (want.delim == elink_pkg::DELIM_DATA)
        begin
          seen[want.data] = 1'b1;
        end
        if (want.delim == elink_pkg::DELIM_EOP)
        begin
          rd_pkt++;
          rd_pos = 0;
        end
        else
        begin
          rd_pos++;
        end
      end
    end
  end

  initial
  begin
    int next_len;
    int n_seen;
    clk           = 1'b0;
    rst_n         = 1'b0;
    loop_en       = 1'b0;
    packet_len    = 8'd4;
    rx_rd_en      = 1'b0;
    seed          = 32'h35680b1d;
    n_lens        = 0;
    payload_total = 0;
    rd_pkt        = 0;
    rd_pos        = 0;
    for (int i = 0; i < 256; i++)
    begin
      seen[i] = 1'b0;
    end

    test_name = "reset";
    for (int i = 0; i < 10; i++)
    begin
      @(posedge clk);
      if (i > 0)
      begin
        check_reset_state();
      end
    end
    rst_n <= 1'b1;
    @(posedge clk);
    check_reset_state();

    test_name = "alignment";
    wait_aligned(200);
    repeat (50)
    begin
      @(posedge clk);
      check_value(test_name, 32'd1, rx_empty);
    end

    test_name = "framing";
    start_next(4);
    loop_en <= 1'b1;
    for (int p = 0; p < 3; p++)
    begin
      wait_done(400);
      start_next(4);
    end

    // random lengths until the byte count has wrapped past 255.
    test_name = "payload";
    while (payload_total <= 300 && n_lens < MAX_PKTS - 2)
    begin
      wait_done(400);
      next_len = 1 + int'($unsigned($random(seed)) % 32);
      start_next(next_len);
    end

    test_name = "stop";
    wait_done(400);
    start_next(20);
    repeat (40) @(posedge clk);
    loop_en <= 1'b0;
    wait_done(400);
    // every word still queued in either FIFO needs one symbol time on the link.
    wait_drained(4 * (elink_pkg::TX_FIFO_DEPTH + elink_pkg::RX_FIFO_DEPTH) *
                 elink_pkg::SYM_BEATS);
    repeat (300)
    begin
      @(posedge clk);
      check_value(test_name, 32'd1, rx_empty);
    end

    test_name = "payload";
    n_seen = 0;
    for (int i = 0; i < 256; i++)
    begin
      n_seen += seen[i];
    end
    check_value(test_name, 32'd256, n_seen);

    test_name = "integrity";
    check_value(test_name, 32'd0, rx_code_err);
    check_value(test_name, 32'd0, rx_overflow);
    check_value(test_name, 32'd1, rx_aligned);

    $display("Result: PASSED");
    $finish;
  end

endmodule

// ==== logic/elink_loopback_top.sv ====
module elink_loopback_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   loop_en,
  input  logic [7:0]             packet_len,
  input  logic                   rx_rd_en,
  output elink_pkg::elink_word_t rx_word,
  output logic                   rx_empty,
  output logic                   rx_aligned,
  output logic                   rx_code_err,
  output logic                   rx_overflow,
  output logic                   done
);

  elink_pkg::elink_word_t tx_word;
  logic       tx_wr_en;
  logic       tx_full;
  logic [1:0] link;

  data_gen_elink_sm u_gen (
    .clk        (clk),
    .rst_n      (rst_n),
    .loop_en    (loop_en),
    .packet_len (packet_len),
    .tx_full    (tx_full),
    .tx_wr_en   (tx_wr_en),
    .tx_word    (tx_word),
    .done       (done)
  );

  fifo_to_elink u_tx (
    .clk   (clk),
    .rst_n (rst_n),
    .wr_en (tx_wr_en),
    .din   (tx_word),
    .full  (tx_full),
    .link  (link)
  );

  elink_to_fifo u_rx (
    .clk      (clk),
    .rst_n    (rst_n),
    .link     (link),
    .rd_en    (rx_rd_en),
    .dout     (rx_word),
    .empty    (rx_empty),
    .aligned  (rx_aligned),
    .code_err (rx_code_err),
    .overflow (rx_overflow)
  );

endmodule

// ==== logic/elink_to_fifo.sv ====
module elink_to_fifo (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [1:0]             link,
  input  logic                   rd_en,
  output elink_pkg::elink_word_t dout,
  output logic                   empty,
  output logic                   aligned,
  output logic                   code_err,
  output logic                   overflow
);

  logic [11:0] hist;
  logic [2:0]  bcnt;
  logic [2:0]  lock_phase;
  logic [2:0]  cand_phase;
  logic        lock_off;
  logic        cand_off;
  logic        cand_vld;
  logic        hit0;
  logic        hit1;
  logic        sym_load;
  logic        dec_vld;
  logic [7:0]  dec_dout;
  logic        dec_k;
  logic        dec_err;
  logic        bad_k;
  logic        keep;
  logic        fifo_full;
  logic        wr_en;
  elink_pkg::elink_word_t word;

  assign hit0 = (hist[11:2] == elink_pkg::COMMA_N) || (hist[11:2] == elink_pkg::COMMA_P);
  assign hit1 = (hist[10:1] == elink_pkg::COMMA_N) || (hist[10:1] == elink_pkg::COMMA_P);
  assign sym_load = aligned && (bcnt == lock_phase);

  dec_8b10b u_dec (
    .clk   (clk),
    .rst_n (rst_n),
    .load  (sym_load),
    .din   (lock_off ? hist[10:1] : hist[11:2]),
    .dout  (dec_dout),
    .k     (dec_k),
    .err   (dec_err)
  );

  always_comb
  begin
    word.data  = dec_dout;
    word.delim = elink_pkg::DELIM_DATA;
    keep       = !dec_err;
    bad_k      = 1'b0;
    if (dec_k)
    begin
      case (dec_dout)
        elink_pkg::K28_1: word.delim = elink_pkg::DELIM_SOP;
        elink_pkg::K28_6: word.delim = elink_pkg::DELIM_EOP;
        elink_pkg::K28_5: keep = 1'b0;
        default:
        begin
          keep  = 1'b0;
          bad_k = 1'b1;
        end
      endcase
    end
  end

  assign wr_en = dec_vld && keep && !fifo_full;

  sync_fifo #(.DEPTH(elink_pkg::RX_FIFO_DEPTH)) u_rx_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .wr_en (wr_en),
    .rd_en (rd_en),
    .din   (word),
    .dout  (dout),
    .full  (fifo_full),
    .empty (empty)
  );

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      hist       <= '0;
      bcnt       <= '0;
      aligned    <= 1'b0;
      lock_off   <= 1'b0;
      lock_phase <= '0;
      cand_vld   <= 1'b0;
      cand_off   <= 1'b0;
      cand_phase <= '0;
      dec_vld    <= 1'b0;
      code_err   <= 1'b0;
      overflow   <= 1'b0;
    end
    else
    begin
      // the first received pair ends up lowest once a symbol has shifted in.
      hist    <= {link, hist[11:2]};
      bcnt    <= (bcnt == 3'(elink_pkg::SYM_BEATS - 1)) ? '0 : bcnt + 3'd1;
      dec_vld <= sym_load;
      if (!aligned && (hit0 || hit1))
      begin
        if (cand_vld && cand_off == !hit0 && cand_phase == bcnt)
        begin
          aligned    <= 1'b1;
          lock_off   <= !hit0;
          lock_phase <= bcnt;
        end
        cand_vld   <= 1'b1;
        cand_off   <= !hit0;
        cand_phase <= bcnt;
      end
      if (dec_vld && (dec_err || bad_k))
      begin
        code_err <= 1'b1;
      end
      if (dec_vld && keep && fifo_full)
      begin
        overflow <= 1'b1;
      end
    end
  end

endmodule

// ==== logic/dec_8b10b.sv ====
module dec_8b10b (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       load,
  input  logic [9:0] din,
  output logic [7:0] dout,
  output logic       k,
  output logic       err
);

  logic       rd;
  logic       first;
  logic [5:0] six;
  logic [3:0] four;
  logic [4:0] x;
  logic [2:0] y;
  logic       k28;
  logic       ok6;
  logic       ok4;
  logic       rd_mid;
  logic       rd_end;
  logic       disp_err;

  assign six  = din[9:4];
  assign k28  = (six == 6'b001111) || (six == 6'b110000);
  // K28 in positive form carries an inverted 4b code.
  assign four = (six == 6'b110000) ? ~din[3:0] : din[3:0];

  always_comb
  begin
    logic [5:0] c6;
    logic [3:0] c4;
    x   = 5'd28;
    y   = '0;
    ok6 = k28;
    ok4 = 1'b0;
    for (int i = 31; i >= 0; i--)
    begin
      c6 = elink_pkg::code_6b(5'(i));
      if (six == c6 || (six == ~c6 && ($countones(c6) != 3 || c6 == 6'b111000)))
      begin
        x   = 5'(i);
        ok6 = 1'b1;
      end
    end
    for (int j = 7; j >= 0; j--)
    begin
      c4 = elink_pkg::code_4b(3'(j));
      if (four == c4 || (four == ~c4 && ($countones(c4) != 2 || c4 == 4'b1100)))
      begin
        y   = 3'(j);
        ok4 = 1'b1;
      end
    end
    if (four == 4'b0111 || four == 4'b1000)
    begin
      y   = 3'd7;
      ok4 = 1'b1;
    end

    // an unbalanced block must move the running disparity the other way.
    disp_err = 1'b0;
    rd_mid   = rd;
    if ($countones(six) != 3)
    begin
      disp_err = ($countones(six) > 3) == rd;
      rd_mid   = $countones(six) > 3;
    end
    rd_end = rd_mid;
    if ($countones(din[3:0]) != 2)
    begin
      disp_err = disp_err || (($countones(din[3:0]) > 2) == rd_mid);
      rd_end   = $countones(din[3:0]) > 2;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rd    <= 1'b0;
      first <= 1'b1;
      err   <= 1'b0;
    end
    else if (load)
    begin
      rd    <= rd_end;
      first <= 1'b0;
      err   <= !ok6 || !ok4 || (disp_err && !first);
    end
  end

  always_ff @(posedge clk)
  begin
    if (load)
    begin
      dout <= {y, x};
      k    <= k28;
    end
  end

endmodule

// ==== logic/fifo_to_elink.sv ====
module fifo_to_elink (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   wr_en,
  input  elink_pkg::elink_word_t din,
  output logic                   full,
  output logic [1:0]             link
);

  elink_pkg::elink_word_t fifo_dout;
  logic       fifo_empty;
  logic       pop;
  logic       enc_load;
  logic [7:0] enc_din;
  logic       enc_k;
  logic [9:0] enc_dout;
  logic [2:0] beat;
  logic [9:0] sreg;

  // the encoder is loaded two beats before the end so its output is ready to shift.
  assign enc_load = (beat == 3'(elink_pkg::SYM_BEATS - 2));
  assign pop      = enc_load && !fifo_empty;

  always_comb
  begin
    enc_k   = 1'b1;
    enc_din = elink_pkg::K28_5;
    if (!fifo_empty)
    begin
      case (fifo_dout.delim)
        elink_pkg::DELIM_DATA:
        begin
          enc_k   = 1'b0;
          enc_din = fifo_dout.data;
        end
        elink_pkg::DELIM_SOP: enc_din = elink_pkg::K28_1;
        elink_pkg::DELIM_EOP: enc_din = elink_pkg::K28_6;
        default:              enc_din = elink_pkg::K28_5;
      endcase
    end
  end

  sync_fifo #(.DEPTH(elink_pkg::TX_FIFO_DEPTH)) u_tx_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .wr_en (wr_en),
    .rd_en (pop),
    .din   (din),
    .dout  (fifo_dout),
    .full  (full),
    .empty (fifo_empty)
  );

  enc_8b10b u_enc (
    .clk   (clk),
    .rst_n (rst_n),
    .load  (enc_load),
    .din   (enc_din),
    .k     (enc_k),
    .dout  (enc_dout)
  );

  assign link = sreg[1:0];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      beat <= '0;
      sreg <= '0;
    end
    else if (beat == 3'(elink_pkg::SYM_BEATS - 1))
    begin
      beat <= '0;
      sreg <= enc_dout;
    end
    else
    begin
      beat <= beat + 3'd1;
      sreg <= {2'b00, sreg[9:2]};
    end
  end

endmodule

// ==== logic/enc_8b10b.sv ====
module enc_8b10b (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       load,
  input  logic [7:0] din,
  input  logic       k,
  output logic [9:0] dout
);

  logic       rd;
  logic       rd_mid;
  logic       rd_end;
  logic [4:0] x;
  logic [2:0] y;
  logic [5:0] six;
  logic [3:0] four;
  logic       alt7;

  assign x = din[4:0];
  assign y = din[7:5];

  // alternate D.x.7 avoids a run of five equal bits across the block boundary.
  assign alt7 = !k && (y == 3'd7) &&
                ((!rd_mid && (x == 5'd17 || x == 5'd18 || x == 5'd20)) ||
                 (rd_mid && (x == 5'd11 || x == 5'd13 || x == 5'd14)));

  always_comb
  begin
    six = k ? 6'b001111 : elink_pkg::code_6b(x);
    if (rd && ($countones(six) != 3 || six == 6'b111000))
    begin
      six = ~six;
    end
    rd_mid = ($countones(six) != 3) ? ~rd : rd;

    four = alt7 ? 4'b0111 : elink_pkg::code_4b(y);
    if (k)
    begin
      // K28.y inverts its balanced 4b code when the 6b block ended negative.
      if (!rd_mid)
      begin
        four = ~four;
      end
    end
    else if (rd_mid && ($countones(four) != 2 || four == 4'b1100))
    begin
      four = ~four;
    end
    rd_end = ($countones(four) != 2) ? ~rd_mid : rd_mid;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rd <= 1'b0;
    end
    else if (load)
    begin
      rd <= rd_end;
    end
  end

  always_ff @(posedge clk)
  begin
    if (load)
    begin
      dout <= {six, four};
    end
  end

endmodule

// ==== logic/data_gen_elink_sm.sv ====
module data_gen_elink_sm (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   loop_en,
  input  logic [7:0]             packet_len,
  input  logic                   tx_full,
  output logic                   tx_wr_en,
  output elink_pkg::elink_word_t tx_word,
  output logic                   done
);

  elink_pkg::gen_state_e state;
  logic [7:0] payload;
  logic [7:0] byte_cnt;
  logic [7:0] len_q;

  // a word is offered in every state but idle and written once there is room.
  assign tx_wr_en = (state != elink_pkg::GEN_IDLE) && !tx_full;
  assign done     = (state == elink_pkg::GEN_EOP) && tx_wr_en;

  always_comb
  begin
    case (state)
      elink_pkg::GEN_SOP:
      begin
        tx_word.delim = elink_pkg::DELIM_SOP;
        tx_word.data  = elink_pkg::K28_1;
      end
      elink_pkg::GEN_EOP:
      begin
        tx_word.delim = elink_pkg::DELIM_EOP;
        tx_word.data  = elink_pkg::K28_6;
      end
      default:
      begin
        tx_word.delim = elink_pkg::DELIM_DATA;
        tx_word.data  = payload;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= elink_pkg::GEN_IDLE;
      payload  <= '0;
      byte_cnt <= '0;
      len_q    <= 8'd1;
    end
    else
    begin
      case (state)
        elink_pkg::GEN_IDLE:
        begin
          if (loop_en)
          begin
            state <= elink_pkg::GEN_SOP;
          end
        end
        elink_pkg::GEN_SOP:
        begin
          if (tx_wr_en)
          begin
            len_q    <= packet_len;
            byte_cnt <= '0;
            state    <= elink_pkg::GEN_DATA;
          end
        end
        elink_pkg::GEN_DATA:
        begin
          if (tx_wr_en)
          begin
            payload  <= payload + 8'd1;
            byte_cnt <= byte_cnt + 8'd1;
            if (byte_cnt == len_q - 8'd1)
            begin
              state <= elink_pkg::GEN_EOP;
            end
          end
        end
        default:
        begin
          if (tx_wr_en)
          begin
            state <= loop_en ? elink_pkg::GEN_SOP : elink_pkg::GEN_IDLE;
          end
        end
      endcase
    end
  end

  a_word_held : assert property (@(posedge clk) disable iff (!rst_n)
    (state != elink_pkg::GEN_IDLE && tx_full) |=> $stable(tx_word));

endmodule

// ==== logic/sync_fifo.sv ====
module sync_fifo #(
  parameter int DEPTH = 16
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  wr_en,
  input  logic                  rd_en,
  input  elink_pkg::elink_word_t din,
  output elink_pkg::elink_word_t dout,
  output logic                  full,
  output logic                  empty
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  elink_pkg::elink_word_t mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;
  logic          do_wr;
  logic          do_rd;

  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;
  assign full  = (count == (AW+1)'(DEPTH));
  assign empty = (count == '0);
  assign dout  = mem[rd_ptr];

  always_ff @(posedge clk)
  begin
    if (do_wr)
    begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_wr)
      begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd)
      begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + (AW+1)'(do_wr) - (AW+1)'(do_rd);
    end
  end

  a_no_write_full : assert property (@(posedge clk) disable iff (!rst_n) !(wr_en && full));
  a_no_read_empty : assert property (@(posedge clk) disable iff (!rst_n) !(rd_en && empty));

endmodule

// ==== logic/elink_pkg.sv ====
package elink_pkg;

  // delimiter carried in the upper two bits of every e-link word.
  typedef enum logic [1:0] {
    DELIM_DATA  = 2'b00,
    DELIM_SOP   = 2'b01,
    DELIM_EOP   = 2'b10,
    DELIM_COMMA = 2'b11
  } elink_delim_e;

  typedef struct packed {
    elink_delim_e delim;
    logic [7:0]   data;
  } elink_word_t;

  typedef enum logic [1:0] {
    GEN_IDLE,
    GEN_SOP,
    GEN_DATA,
    GEN_EOP
  } gen_state_e;

  localparam logic [7:0] K28_5 = 8'hBC;
  localparam logic [7:0] K28_1 = 8'h3C;
  localparam logic [7:0] K28_6 = 8'hDC;

  // K28.5 in both disparities, bit 9 is the first code bit (a).
  localparam logic [9:0] COMMA_N = 10'h0FA;
  localparam logic [9:0] COMMA_P = 10'h305;

  localparam int TX_FIFO_DEPTH = 16;
  localparam int RX_FIFO_DEPTH = 16;
  localparam int SYM_BEATS     = 5;

  // 5b/6b code for EDCBA, given in its negative disparity form (abcdei).
  function automatic logic [5:0] code_6b(input logic [4:0] x);
    logic [5:0] c;
    case (x)
      5'd0:  c = 6'b100111;
      5'd1:  c = 6'b011101;
      5'd2:  c = 6'b101101;
      5'd3:  c = 6'b110001;
      5'd4:  c = 6'b110101;
      5'd5:  c = 6'b101001;
      5'd6:  c = 6'b011001;
      5'd7:  c = 6'b111000;
      5'd8:  c = 6'b111001;
      5'd9:  c = 6'b100101;
      5'd10: c = 6'b010101;
      5'd11: c = 6'b110100;
      5'd12: c = 6'b001101;
      5'd13: c = 6'b101100;
      5'd14: c = 6'b011100;
      5'd15: c = 6'b010111;
      5'd16: c = 6'b011011;
      5'd17: c = 6'b100011;
      5'd18: c = 6'b010011;
      5'd19: c = 6'b110010;
      5'd20: c = 6'b001011;
      5'd21: c = 6'b101010;
      5'd22: c = 6'b011010;
      5'd23: c = 6'b111010;
      5'd24: c = 6'b110011;
      5'd25: c = 6'b100110;
      5'd26: c = 6'b010110;
      5'd27: c = 6'b110110;
      5'd28: c = 6'b001110;
      5'd29: c = 6'b101110;
      5'd30: c = 6'b011110;
      default: c = 6'b101011;
    endcase
    return c;
  endfunction

  // 3b/4b code for HGF in negative disparity form (fghj), primary D.x.7.
  function automatic logic [3:0] code_4b(input logic [2:0] y);
    logic [3:0] c;
    case (y)
      3'd0: c = 4'b1011;
      3'd1: c = 4'b1001;
      3'd2: c = 4'b0101;
      3'd3: c = 4'b1100;
      3'd4: c = 4'b1101;
      3'd5: c = 4'b1010;
      3'd6: c = 4'b0110;
      default: c = 4'b1110;
    endcase
    return c;
  endfunction

endpackage
